// File: src/lut_data_pkg.sv
package lut_data_pkg;

    // datapath widths
    localparam int ITEM_W = 32;
    localparam int ACC_W = 32;
    localparam int INDEX_W = 8;
    localparam int CORE_SEL_W = 4;

    // one table word in a core's item memory
    typedef logic [ITEM_W-1:0] item_t;

    // running sum that wraps modulo 2^32
    typedef logic [ACC_W-1:0] acc_t;

    // table index broadcast to all cores
    typedef logic [INDEX_W-1:0] index_t;

    // core number on the memory write port
    typedef logic [CORE_SEL_W-1:0] core_sel_t;

endpackage

// File: src/drain_ctrl_pkg.sv
package drain_ctrl_pkg;

    // intake controller
    // OPEN  accepting indices
    // HOLD  frame closed, waiting for its results to drain
    typedef enum logic [0:0] {
        OPEN = 1'b0,
        HOLD = 1'b1
    } intake_state_t;

    // drain controller
    // IDLE   no results pending
    // LOAD   snapshots copied into the chain
    // SHIFT  chain presented on the output, one core per beat
    typedef enum logic [1:0] {
        IDLE  = 2'b00,
        LOAD  = 2'b01,
        SHIFT = 2'b10
    } drain_state_t;

endpackage

// File: src/index_intake.sv
`timescale 1ns/1ps

module index_intake (
    input  logic                  clk,
    input  logic                  arst_n,
    // index stream
    input  logic                  in_valid,
    input  lut_data_pkg::index_t  in_index,
    input  logic                  in_last,
    output logic                  in_ready,
    // from the drain side
    input  logic                  drain_busy,
    // issue slot, one pulse per accepted index
    output logic                  issue_en,
    output lut_data_pkg::index_t  issue_index,
    output logic                  issue_last
);

    drain_ctrl_pkg::intake_state_t state_q;
    logic                          busy_q;
    logic                          accept;
    logic                          drain_done;

    // input open only outside HOLD
    assign in_ready = (state_q == drain_ctrl_pkg::OPEN);
    assign accept = in_valid && in_ready;

    // falling edge of drain_busy, i.e. final result beat went out
    // busy is still low for a few cycles after the last index,
    // so the level alone cannot reopen the input
    assign drain_done = busy_q && !drain_busy;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q    <= drain_ctrl_pkg::OPEN;
            busy_q     <= 1'b0;
            issue_en   <= 1'b0;
            issue_last <= 1'b0;
        end else begin
            busy_q     <= drain_busy;
            // issue slot lives for exactly one cycle
            issue_en   <= accept;
            issue_last <= accept && in_last;

            case (state_q)
                drain_ctrl_pkg::OPEN: begin
                    // last beat closes the frame
                    if (accept && in_last) begin
                        state_q <= drain_ctrl_pkg::HOLD;
                    end
                end
                drain_ctrl_pkg::HOLD: begin
                    if (drain_done) begin
                        state_q <= drain_ctrl_pkg::OPEN;
                    end
                end
                default: begin
                    state_q <= drain_ctrl_pkg::OPEN;
                end
            endcase
        end
    end

    // index payload
    always_ff @(posedge clk) begin
        if (accept) begin
            issue_index <= in_index;
        end
    end

endmodule

// File: src/lut_core.sv
`timescale 1ns/1ps

module lut_core #(
    parameter int MEM_DEPTH = 128
) (
    input  logic                  clk,
    input  logic                  arst_n,
    // item memory write
    input  logic                  wr_en,
    input  lut_data_pkg::index_t  wr_addr,
    input  lut_data_pkg::item_t   wr_data,
    // broadcast index
    input  logic                  issue_en,
    input  lut_data_pkg::index_t  issue_index,
    input  logic                  issue_last,
    // result chain
    input  logic                  load_chain,
    input  logic                  shift_chain,
    input  lut_data_pkg::acc_t    chain_in,
    output lut_data_pkg::acc_t    chain_out,
    output logic                  captured
);

    localparam int ADDR_W = (MEM_DEPTH > 1) ? $clog2(MEM_DEPTH) : 1;

    lut_data_pkg::item_t  item_mem [MEM_DEPTH];

    // stage 1, registered issue
    logic                 idx_vld;
    logic                 idx_last;
    lut_data_pkg::index_t idx_q;
    // stage 2, memory read
    logic                 rd_vld;
    logic                 rd_last;
    lut_data_pkg::item_t  rd_data;
    // stage 3, accumulate
    lut_data_pkg::acc_t   acc;
    lut_data_pkg::acc_t   snapshot;
    lut_data_pkg::acc_t   sum_next;

    // wraps naturally at 32 bits
    assign sum_next = acc + lut_data_pkg::acc_t'(rd_data);

    // control flags follow the data down the pipe
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            idx_vld  <= 1'b0;
            idx_last <= 1'b0;
            rd_vld   <= 1'b0;
            rd_last  <= 1'b0;
            acc      <= '0;
            captured <= 1'b0;
        end else begin
            idx_vld  <= issue_en;
            idx_last <= issue_en && issue_last;
            rd_vld   <= idx_vld;
            rd_last  <= idx_last;
            captured <= rd_vld && rd_last;
            if (rd_vld) begin
                // last add goes to the snapshot, acc restarts at zero
                acc <= rd_last ? '0 : sum_next;
            end
        end
    end

    // index register, cuts the broadcast fanout from the ram address
    always_ff @(posedge clk) begin
        if (issue_en) begin
            idx_q <= issue_index;
        end
    end

    // item memory, one write and one registered read port
    always_ff @(posedge clk) begin
        if (wr_en) begin
            item_mem[wr_addr[ADDR_W-1:0]] <= wr_data;
        end
        if (idx_vld) begin
            rd_data <= item_mem[idx_q[ADDR_W-1:0]];
        end
    end

    // frame sum, held until the next frame ends
    always_ff @(posedge clk) begin
        if (rd_vld && rd_last) begin
            snapshot <= sum_next;
        end
    end

    // chain stage: load own sum, or take the neighbour's
    always_ff @(posedge clk) begin
        if (load_chain) begin
            chain_out <= snapshot;
        end else if (shift_chain) begin
            chain_out <= chain_in;
        end
    end

endmodule

// File: src/core_array.sv
`timescale 1ns/1ps

module core_array #(
    parameter int NUM_CORES = 8,
    parameter int MEM_DEPTH = 128
) (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     mem_wr_en,
    input  lut_data_pkg::core_sel_t  mem_wr_core,
    input  lut_data_pkg::index_t     mem_wr_addr,
    input  lut_data_pkg::item_t      mem_wr_data,
    input  logic                     issue_en,
    input  lut_data_pkg::index_t     issue_index,
    input  logic                     issue_last,
    input  logic                     load_chain,
    input  logic                     shift_chain,
    output lut_data_pkg::acc_t       chain_out,
    output logic                     frame_done
);

    // link[i] is core i's chain register, link[NUM_CORES] is the zero fill
    lut_data_pkg::acc_t  chain_link [NUM_CORES+1];
    logic [NUM_CORES-1:0] core_wr_en;
    logic [NUM_CORES-1:0] core_captured;

    assign chain_link[NUM_CORES] = '0;

    for (genvar i = 0; i < NUM_CORES; i++) begin : g_core
        // write decode
        assign core_wr_en[i] = mem_wr_en
            && (mem_wr_core == lut_data_pkg::core_sel_t'(i));

        lut_core #(
            .MEM_DEPTH   (MEM_DEPTH)
        ) u_core (
            .clk         (clk),
            .arst_n      (arst_n),
            .wr_en       (core_wr_en[i]),
            .wr_addr     (mem_wr_addr),
            .wr_data     (mem_wr_data),
            .issue_en    (issue_en),
            .issue_index (issue_index),
            .issue_last  (issue_last),
            .load_chain  (load_chain),
            .shift_chain (shift_chain),
            .chain_in    (chain_link[i+1]),
            .chain_out   (chain_link[i]),
            .captured    (core_captured[i])
        );
    end

    // all cores run in lockstep, core 0 stands for the array
    assign frame_done = core_captured[0];
    // head of the chain
    assign chain_out = chain_link[0];

endmodule

// File: src/result_drain.sv
`timescale 1ns/1ps

module result_drain #(
    parameter int NUM_CORES = 8
) (
    input  logic                clk,
    input  logic                arst_n,
    // from the array
    input  logic                frame_done,
    input  lut_data_pkg::acc_t  chain_out,
    // chain control
    output logic                load_chain,
    output logic                shift_chain,
    output logic                drain_busy,
    // result stream
    output logic                out_valid,
    output lut_data_pkg::acc_t  out_data,
    output logic                out_last,
    input  logic                out_ready
);

    localparam int CNT_W = (NUM_CORES > 1) ? $clog2(NUM_CORES) : 1;
    localparam logic [CNT_W-1:0] LAST_BEAT = CNT_W'(NUM_CORES - 1);

    drain_ctrl_pkg::drain_state_t state_q;
    logic [CNT_W-1:0]             beat_cnt;
    logic                         xfer;
    logic                         final_beat;

    // outputs decode straight from the state
    assign load_chain = (state_q == drain_ctrl_pkg::LOAD);
    assign out_valid  = (state_q == drain_ctrl_pkg::SHIFT);
    assign drain_busy = (state_q != drain_ctrl_pkg::IDLE);

    // head of chain is the current beat, holds while the chain holds
    assign out_data = chain_out;

    assign final_beat  = (beat_cnt == LAST_BEAT);
    assign out_last    = out_valid && final_beat;
    assign xfer        = out_valid && out_ready;
    // each transfer pulls the next core forward
    assign shift_chain = xfer;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q  <= drain_ctrl_pkg::IDLE;
            beat_cnt <= '0;
        end else begin
            case (state_q)
                drain_ctrl_pkg::IDLE: begin
                    beat_cnt <= '0;
                    if (frame_done) begin
                        state_q <= drain_ctrl_pkg::LOAD;
                    end
                end
                drain_ctrl_pkg::LOAD: begin
                    // snapshots enter the chain on this edge
                    state_q <= drain_ctrl_pkg::SHIFT;
                end
                drain_ctrl_pkg::SHIFT: begin
                    if (xfer) begin
                        if (final_beat) begin
                            state_q  <= drain_ctrl_pkg::IDLE;
                            beat_cnt <= '0;
                        end else begin
                            beat_cnt <= beat_cnt + 1'b1;
                        end
                    end
                end
                default: begin
                    state_q <= drain_ctrl_pkg::IDLE;
                end
            endcase
        end
    end

endmodule

// File: src/lut_accum_top.sv
`timescale 1ns/1ps

module lut_accum_top #(
    parameter int NUM_CORES = 8,
    parameter int MEM_DEPTH = 128
) (
    input  logic                     clk,
    input  logic                     arst_n,
    // item memory load
    input  logic                     mem_wr_en,
    input  lut_data_pkg::core_sel_t  mem_wr_core,
    input  lut_data_pkg::index_t     mem_wr_addr,
    input  lut_data_pkg::item_t      mem_wr_data,
    // index stream in
    input  logic                     in_valid,
    input  lut_data_pkg::index_t     in_index,
    input  logic                     in_last,
    output logic                     in_ready,
    // result stream out
    output logic                     out_valid,
    output lut_data_pkg::acc_t       out_data,
    output logic                     out_last,
    input  logic                     out_ready
);

    // intake to array
    logic                  issue_en;
    lut_data_pkg::index_t  issue_index;
    logic                  issue_last;
    // array and drain
    logic                  frame_done;
    logic                  load_chain;
    logic                  shift_chain;
    logic                  drain_busy;
    lut_data_pkg::acc_t    chain_out;

    index_intake u_intake (
        .clk         (clk),
        .arst_n      (arst_n),
        .in_valid    (in_valid),
        .in_index    (in_index),
        .in_last     (in_last),
        .in_ready    (in_ready),
        .drain_busy  (drain_busy),
        .issue_en    (issue_en),
        .issue_index (issue_index),
        .issue_last  (issue_last)
    );

    core_array #(
        .NUM_CORES   (NUM_CORES),
        .MEM_DEPTH   (MEM_DEPTH)
    ) u_array (
        .clk         (clk),
        .arst_n      (arst_n),
        .mem_wr_en   (mem_wr_en),
        .mem_wr_core (mem_wr_core),
        .mem_wr_addr (mem_wr_addr),
        .mem_wr_data (mem_wr_data),
        .issue_en    (issue_en),
        .issue_index (issue_index),
        .issue_last  (issue_last),
        .load_chain  (load_chain),
        .shift_chain (shift_chain),
        .chain_out   (chain_out),
        .frame_done  (frame_done)
    );

    result_drain #(
        .NUM_CORES   (NUM_CORES)
    ) u_drain (
        .clk         (clk),
        .arst_n      (arst_n),
        .frame_done  (frame_done),
        .chain_out   (chain_out),
        .load_chain  (load_chain),
        .shift_chain (shift_chain),
        .drain_busy  (drain_busy),
        .out_valid   (out_valid),
        .out_data    (out_data),
        .out_last    (out_last),
        .out_ready   (out_ready)
    );

endmodule

// File: test/lut_accum_sva.sv
`timescale 1ns/1ps

module lut_accum_sva (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                in_ready,
    input  logic                drain_busy,
    input  logic                out_valid,
    input  lut_data_pkg::acc_t  out_data,
    input  logic                out_ready
);

    // running count of assertion failures
    int unsigned fail_cnt = 0;

    // beat frozen under back-pressure
    assert property (@(posedge clk) disable iff (!arst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data))
    else begin
        fail_cnt++;
        $error("result beat changed or dropped while out_ready was low");
    end

    // no new indices while results drain
    assert property (@(posedge clk) disable iff (!arst_n) drain_busy |-> !in_ready)
    else begin
        fail_cnt++;
        $error("index input open while a frame was draining");
    end

    // quiet output during reset
    assert property (@(posedge clk) !arst_n |-> !out_valid)
    else begin
        fail_cnt++;
        $error("out_valid high during reset");
    end

endmodule

bind lut_accum_top lut_accum_sva u_sva (
    .clk        (clk),
    .arst_n     (arst_n),
    .in_ready   (in_ready),
    .drain_busy (drain_busy),
    .out_valid  (out_valid),
    .out_data   (out_data),
    .out_ready  (out_ready)
);

// File: test/tb_lut_accum.sv
`timescale 1ns/1ps

module tb_lut_accum;

    localparam int NUM_CORES = 8;
    localparam int MEM_DEPTH = 128;
    // cycles any single wait may take
    localparam int TIMEOUT = 4000;

    logic                     clk;
    logic                     arst_n;
    logic                     mem_wr_en;
    lut_data_pkg::core_sel_t  mem_wr_core;
    lut_data_pkg::index_t     mem_wr_addr;
    lut_data_pkg::item_t      mem_wr_data;
    logic                     in_valid;
    lut_data_pkg::index_t     in_index;
    logic                     in_last;
    logic                     in_ready;
    logic                     out_valid;
    lut_data_pkg::acc_t       out_data;
    logic                     out_last;
    logic                     out_ready;

    // reference model: item copy per core and expected beats in drain order
    lut_data_pkg::item_t mem_model [NUM_CORES][MEM_DEPTH];
    lut_data_pkg::acc_t  exp_q [$];
    int                  frame_q [$];
    int                  seed = 3959;
    int                  errors = 0;
    int                  timeouts = 0;
    // frames whose last index went in but whose last result is not out yet
    int                  pending_frames = 0;
    bit                  ready_random = 1'b0;
    string               test_name = "reset";

    lut_accum_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic int rand_index();
        rand_index = {$random(seed)} % MEM_DEPTH;
    endfunction

    // one item into one core, mirrored in the model
    task automatic write_item(input int core, input int addr, input lut_data_pkg::item_t data);
        mem_wr_en   = 1'b1;
        mem_wr_core = lut_data_pkg::core_sel_t'(core);
        mem_wr_addr = lut_data_pkg::index_t'(addr);
        mem_wr_data = data;
        mem_model[core][addr] = data;
        @(negedge clk);
        mem_wr_en = 1'b0;
    endtask

    // sends frame_q as one frame, in_valid stays up if hold_valid
    task automatic send_frame(input bit hold_valid);
        lut_data_pkg::acc_t sum;
        int                 wait_cnt;
        // sums per core, wrapping at 32 bits
        for (int c = 0; c < NUM_CORES; c++) begin
            sum = '0;
            foreach (frame_q[i]) begin
                sum += mem_model[c][frame_q[i]];
            end
            exp_q.push_back(sum);
        end
        foreach (frame_q[i]) begin
            in_valid = 1'b1;
            in_index = lut_data_pkg::index_t'(frame_q[i]);
            in_last  = (i == frame_q.size() - 1);
            wait_cnt = 0;
            while (!in_ready && timeouts == 0) begin
                @(negedge clk);
                wait_cnt++;
                if (wait_cnt > TIMEOUT) begin
                    timeouts++;
                    $display("timeout in %s: index input never became ready", test_name);
                end
            end
            // ready seen here, beat goes in on the coming rising edge
            @(negedge clk);
        end
        pending_frames++;
        if (!hold_valid) begin
            in_valid = 1'b0;
        end
    endtask

    task automatic random_frame(input bit hold_valid);
        int len;
        len = 1 + {$random(seed)} % 6;
        frame_q.delete();
        repeat (len) frame_q.push_back(rand_index());
        send_frame(hold_valid);
    endtask

    // all expected beats out and the input open again
    task automatic wait_drained();
        int wait_cnt;
        wait_cnt = 0;
        while ((exp_q.size() != 0 || out_valid || !in_ready) && timeouts == 0) begin
            @(negedge clk);
            wait_cnt++;
            if (wait_cnt > TIMEOUT) begin
                timeouts++;
                $display("timeout in %s: results did not drain", test_name);
            end
        end
    endtask

    // output side, every accepted beat compared with the model
    initial begin : drain_check
        int                 beat;
        logic [31:0]        rnd;
        lut_data_pkg::acc_t exp_sum;
        beat = 0;
        forever begin
            @(negedge clk);
            rnd = $random(seed);
            out_ready = ready_random ? rnd[0] : 1'b1;
            if (arst_n && out_valid && out_ready) begin
                assert (exp_q.size() != 0) else begin
                    errors++;
                    $display("%s: output beat %h arrived with no result expected",
                        test_name, out_data);
                end
                if (exp_q.size() != 0) begin
                    exp_sum = exp_q.pop_front();
                    assert (out_data == exp_sum) else begin
                        errors++;
                        $display("CHECK FAILED %s core %0d sum: expected %h actual %h",
                            test_name, beat, exp_sum, out_data);
                    end
                    assert (out_last == (beat == NUM_CORES - 1)) else begin
                        errors++;
                        $display("CHECK FAILED %s core %0d out_last: expected %0d actual %0d",
                            test_name, beat, beat == NUM_CORES - 1, out_last);
                    end
                    if (beat == NUM_CORES - 1) begin
                        beat = 0;
                        pending_frames--;
                    end else begin
                        beat++;
                    end
                end
            end
        end
    end

    // input stays closed while a frame is outstanding
    always @(negedge clk) begin
        if (arst_n && pending_frames > 0) begin
            assert (!in_ready) else begin
                errors++;
                $display("CHECK FAILED %s in_ready: expected 0 actual %0d", test_name, in_ready);
            end
        end
    end

    initial begin : run_tests
        int          a0;
        int          a1;
        int          rc;
        logic [31:0] rnd;
        arst_n      = 1'b1;
        mem_wr_en   = 1'b0;
        mem_wr_core = '0;
        mem_wr_addr = '0;
        mem_wr_data = '0;
        in_valid    = 1'b0;
        in_index    = '0;
        in_last     = 1'b0;
        out_ready   = 1'b1;
        #1 arst_n = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        // idle outputs straight out of reset
        assert (!out_valid && in_ready) else begin
            errors++;
            $display("CHECK FAILED reset out_valid,in_ready: expected 0,1 actual %0d,%0d",
                out_valid, in_ready);
        end

        for (int c = 0; c < NUM_CORES; c++) begin
            for (int a = 0; a < MEM_DEPTH; a++) begin
                write_item(c, a, $random(seed));
            end
        end

        test_name = "single_index";
        frame_q.delete();
        frame_q.push_back(rand_index());
        send_frame(1'b0);
        wait_drained();

        // large items at repeated indices force the 32-bit wrap
        test_name = "multi_index";
        a0 = rand_index();
        a1 = (a0 + 1) % MEM_DEPTH;
        for (int c = 0; c < NUM_CORES; c++) begin
            rnd = $random(seed);
            write_item(c, a0, 32'hf000_0000 | rnd);
            rnd = $random(seed);
            write_item(c, a1, 32'he000_0000 | rnd);
        end
        frame_q = '{a0, a0, a1, a0, a1, rand_index()};
        send_frame(1'b0);
        wait_drained();
        // sum must restart from zero
        random_frame(1'b0);
        wait_drained();

        test_name = "ready_toggle";
        ready_random = 1'b1;
        repeat (6) begin
            random_frame(1'b0);
            wait_drained();
        end

        test_name = "back_to_back";
        repeat (4) random_frame(1'b1);
        random_frame(1'b0);
        wait_drained();
        ready_random = 1'b0;

        test_name = "rewrite";
        rc = {$random(seed)} % NUM_CORES;
        frame_q = '{a0, a1};
        write_item(rc, a0, $random(seed));
        write_item(rc, a1, $random(seed));
        send_frame(1'b0);
        wait_drained();

        repeat (4) @(negedge clk);
        $display("check errors %0d, assertion failures %0d, timeouts %0d",
            errors, DUT.u_sva.fail_cnt, timeouts);
        if (errors == 0 && timeouts == 0 && DUT.u_sva.fail_cnt == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: tb.f
src/lut_data_pkg.sv
src/drain_ctrl_pkg.sv
src/index_intake.sv
src/lut_core.sv
src/core_array.sv
src/result_drain.sv
src/lut_accum_top.sv
test/lut_accum_sva.sv
test/tb_lut_accum.sv

// File: Makefile
TOP := tb_lut_accum

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f tb.f

run: compile
	./obj_dir/V$(TOP) +verilator+error+limit+1000 | tee /dev/stderr \
		| grep -qF "Simulation completed successfully"

clean:
	rm -rf obj_dir
